// ==== fetch_unit.f ====
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/fetch_pc_counter.sv
design/icache_lines.sv
design/fetch_stage.sv
design/fetch_top.sv
testbench/fetch_top_tb.sv

// ==== testbench/fetch_top_tb.sv ====
`timescale 1ns/1ps

module fetch_top_tb import fetch_pkg::*; ();

	localparam int NUM_SLOTS = 4;
	localparam int LINE_W = NUM_SLOTS * 32;
	localparam int WAIT_LIMIT = 40;
	localparam logic [LINE_W-1:0] NOP_LINE = {NUM_SLOTS{NOP_INSTR}};
	localparam fetch_pc_t RESET_FPC = '{bno: RESET_BNO, pc: RESET_PC};
	// Each instruction word is its own byte address scrambled with this key
	localparam logic [31:0] WORD_KEY = 32'hA5C3_0000;

	logic clk, rst, hold_i, redirect_i, fill_i, stomp_i, nmi_i, micro_active_i;
	logic group_valid_o, fetch_stall_o;
	logic [4:0] stomp_bno_i;
	logic [31:0] fill_addr_i;
	logic [LINE_W-1:0] fill_line_i;
	fetch_pc_t redirect_pc_i, micro_adr_i;
	fetch_group_t group_o;

	// Model state. Refills stay in the 16 lines above the reset address,
	// so no two filled lines share a cache entry
	fetch_pc_t exp_pc, m_base;
	fetch_group_t exp_group;
	logic exp_valid, m_warm, m_hit, m_null;
	logic [15:0] filled;
	int warm_left;
	int errors = 0;
	int tests_run = 0;
	integer seed = 30224;

	fetch_top #(.NUM_SLOTS(NUM_SLOTS), .CACHE_LINES(16), .WARMUP_CYCLES(4)) fetch_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [LINE_W-1:0] line_for(input logic [31:0] addr);
		logic [LINE_W-1:0] line;
		for (int k = 0; k < NUM_SLOTS; k++)
			line[k*32 +: 32] = (addr + 32'(4 * k)) ^ WORD_KEY;
		return line;
	endfunction

	// Slot k sits 4k bytes above the base, or on the base itself for micro fetches
	function automatic fetch_group_t make_group(input fetch_pc_t base, input logic same_pc,
			input logic [LINE_W-1:0] line);
		fetch_group_t g;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			g.slot_pc[k].bno = base.bno;
			g.slot_pc[k].pc = same_pc ? base.pc : base.pc + 32'(4 * k);
		end
		g.line = line;
		return g;
	endfunction

	// ======================================================================
	// Reference model
	// ======================================================================

	// The micro address replaces the PC for both the lookup and the slot labels
	assign m_base = micro_active_i ? micro_adr_i : exp_pc;
	assign m_warm = (warm_left == 0);
	assign m_hit = (m_base.pc[31:8] == RESET_PC[31:8]) && filled[m_base.pc[7:4]];
	assign m_null = !m_warm || !m_hit || nmi_i || (stomp_i && m_base.bno != stomp_bno_i);

	always @(posedge clk) begin
		if (rst) begin
			exp_pc <= RESET_FPC;
			exp_group <= make_group(RESET_FPC, 1'b0, NOP_LINE);
			exp_valid <= 1'b0;
			filled <= '0;
			warm_left <= 4;
		end else begin
			if (fill_i && fill_addr_i[31:8] == RESET_PC[31:8])
				filled[fill_addr_i[7:4]] <= 1'b1;
			if (warm_left != 0)
				warm_left <= warm_left - 1;
			// Back-pressure freezes both the PC and the latched group
			if (!hold_i) begin
				exp_group <= make_group(m_base, micro_active_i,
					m_null ? NOP_LINE : line_for(m_base.pc));
				exp_valid <= !m_null;
				if (redirect_i)
					exp_pc <= redirect_pc_i;
				else if (m_warm && m_hit)
					exp_pc.pc <= exp_pc.pc + 32'(NUM_SLOTS * 4);
			end
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic report_mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	// Slot PCs, branch numbers and line data all follow the model
	a_group: assert property (@(posedge clk) disable iff (rst) group_o == exp_group)
		else report_mismatch("group_o differs from the expected fetch group");
	a_valid: assert property (@(posedge clk) disable iff (rst) group_valid_o == exp_valid)
		else report_mismatch("group_valid_o differs from the expected flag");
	// Stall is a same-cycle view of the lookup once warm
	a_stall: assert property (@(posedge clk) disable iff (rst)
		fetch_stall_o == (m_warm && !m_hit))
		else report_mismatch("fetch_stall_o differs from the lookup result");
	a_hold: assert property (@(posedge clk) disable iff (rst)
		hold_i |=> $stable(group_o) && $stable(group_valid_o))
		else report_mismatch("group_o changed while hold_i was high");

	// ======================================================================
	// Stimulus
	// ======================================================================

	// Writes consecutive lines, one per clock
	task automatic fill_lines(input logic [31:0] first, input int count);
		for (int n = 0; n < count; n++) begin
			@(negedge clk);
			fill_i = 1'b1;
			fill_addr_i = first + 32'(16 * n);
			fill_line_i = line_for(first + 32'(16 * n));
		end
		@(negedge clk);
		fill_i = 1'b0;
	endtask

	task automatic pulse_redirect(input logic [4:0] bno, input logic [31:0] pc);
		@(negedge clk);
		redirect_i = 1'b1;
		redirect_pc_i = '{bno: bno, pc: pc};
		@(negedge clk);
		redirect_i = 1'b0;
	endtask

	// One branch number serves both the stomp compare and the micro address
	task automatic set_levels(input logic hold, stomp, nmi, micro, input logic [4:0] bno,
			input logic [31:0] adr);
		@(negedge clk);
		{hold_i, stomp_i, nmi_i, micro_active_i} = {hold, stomp, nmi, micro};
		stomp_bno_i = bno;
		micro_adr_i = '{bno: bno, pc: adr};
	endtask

	// Polls on the falling edge for a stall or a valid group
	task automatic wait_for(input logic want_stall, input string what);
		int n;
		n = 0;
		while (n < WAIT_LIMIT && !(want_stall ? fetch_stall_o : group_valid_o)) begin
			@(negedge clk);
			n++;
		end
		if (!(want_stall ? fetch_stall_o : group_valid_o)) begin
			errors++;
			$display("FAILED: timed out waiting for %s", what);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %0d (%s) finished with %0d errors so far", tests_run, name, errors);
	endtask

	initial begin
		logic [31:0] addr;
		logic [4:0] bno;
		rst = 1'b1;
		{hold_i, redirect_i, fill_i, stomp_i, nmi_i, micro_active_i} = '0;
		{redirect_pc_i, micro_adr_i, fill_addr_i, fill_line_i, stomp_bno_i} = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Lines arrive while warming up, yet only NOPs are latched
		fill_lines(RESET_PC, 6);
		end_test("warm-up");
		// The PC walks through the filled lines one line per clock
		wait_for(1'b0, "the first valid group");
		repeat (3) @(negedge clk);
		end_test("sequential fetch");
		// The seventh line was never filled, so fetch stalls on it
		wait_for(1'b1, "a miss stall");
		repeat (3) @(negedge clk);
		fill_lines(exp_pc.pc, 1);
		wait_for(1'b0, "the refilled line");
		end_test("miss and refill");
		// Random lines are filled, then fetch jumps to the last of them
		repeat (4) begin
			addr = RESET_PC + 32'(($random(seed) & 15) * 16);
			fill_lines(addr, 1);
		end
		pulse_redirect(5'd7, addr);
		wait_for(1'b0, "the redirect target");
		set_levels(1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
		repeat (3) @(negedge clk);
		set_levels(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
		end_test("redirect and hold");
		// Every line of the region is present, so the walk below never misses
		fill_lines(RESET_PC, 16);
		// Stomp a foreign path, raise NMI, then stomp with the current number
		bno = 5'($random(seed));
		if (bno == 5'd3)
			bno = 5'd4;
		pulse_redirect(5'd3, RESET_PC);
		set_levels(1'b0, 1'b1, 1'b0, 1'b0, bno, 32'h0);
		repeat (2) @(negedge clk);
		set_levels(1'b0, 1'b0, 1'b1, 1'b0, 5'd0, 32'h0);
		repeat (2) @(negedge clk);
		set_levels(1'b0, 1'b1, 1'b0, 1'b0, 5'd3, 32'h0);
		wait_for(1'b0, "a line under a matching stomp");
		set_levels(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
		end_test("stomp and interrupt");
		// Micro-machine fetches repeat one address in every slot
		pulse_redirect(5'd2, RESET_PC);
		set_levels(1'b0, 1'b0, 1'b0, 1'b1, 5'd9, RESET_PC + 32'h20);
		repeat (3) @(negedge clk);
		set_levels(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
		wait_for(1'b0, "a group after micro mode");
		end_test("micro-machine address");
		repeat (3) @(negedge clk);
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter int NUM_SLOTS     = 4,
	parameter int CACHE_LINES   = 16,
	parameter int WARMUP_CYCLES = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    hold_i,
	input  logic                    redirect_i,
	input  fetch_pc_t               redirect_pc_i,
	input  logic                    fill_i,
	input  logic [31:0]             fill_addr_i,
	input  logic [NUM_SLOTS*32-1:0] fill_line_i,
	input  logic                    stomp_i,
	input  logic [4:0]              stomp_bno_i,
	input  logic                    nmi_i,
	input  logic                    micro_active_i,
	input  fetch_pc_t               micro_adr_i,
	output fetch_group_t            group_o,
	output logic                    group_valid_o,
	output logic                    fetch_stall_o
);

	fetch_pc_t               pc_cur;
	fetch_pc_t               lookup_pc;
	logic [NUM_SLOTS*32-1:0] cache_line;
	logic                    cache_hit;
	logic                    advance;
	logic                    stage_en;
	logic                    warm;

	// ===================================================================
	// Block connections
	// ===================================================================

	fetch_ctrl #(
		.WARMUP_CYCLES(WARMUP_CYCLES)
	) fetch_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.hold_i       (hold_i),
		.redirect_i   (redirect_i),
		.cache_hit_i  (cache_hit),
		.advance_o    (advance),
		.stage_en_o   (stage_en),
		.warm_o       (warm),
		.fetch_stall_o(fetch_stall_o)
	);

	fetch_pc_counter #(
		.NUM_SLOTS(NUM_SLOTS)
	) fetch_pc_counter_i (
		.clk          (clk),
		.rst          (rst),
		.advance_i    (advance),
		.redirect_i   (redirect_i),
		.redirect_pc_i(redirect_pc_i),
		.hold_i       (hold_i),
		.pc_o         (pc_cur)
	);

	// The cache reads the line that the stage is about to label
	// so micro-machine fetches see their own line
	assign lookup_pc = micro_active_i ? micro_adr_i : pc_cur;

	icache_lines #(
		.NUM_SLOTS  (NUM_SLOTS),
		.CACHE_LINES(CACHE_LINES)
	) icache_lines_i (
		.clk        (clk),
		.rst        (rst),
		.pc_i       (lookup_pc),
		.fill_i     (fill_i),
		.fill_addr_i(fill_addr_i),
		.fill_line_i(fill_line_i),
		.line_o     (cache_line),
		.hit_o      (cache_hit)
	);

	fetch_stage #(
		.NUM_SLOTS(NUM_SLOTS)
	) fetch_stage_i (
		.clk           (clk),
		.rst           (rst),
		.en_i          (stage_en),
		.warm_i        (warm),
		.pc_i          (pc_cur),
		.line_i        (cache_line),
		.hit_i         (cache_hit),
		.stomp_i       (stomp_i),
		.stomp_bno_i   (stomp_bno_i),
		.nmi_i         (nmi_i),
		.micro_active_i(micro_active_i),
		.micro_adr_i   (micro_adr_i),
		.group_o       (group_o),
		.group_valid_o (group_valid_o)
	);

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; #(
	parameter int NUM_SLOTS = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    en_i,
	input  logic                    warm_i,
	input  fetch_pc_t               pc_i,
	input  logic [NUM_SLOTS*32-1:0] line_i,
	input  logic                    hit_i,
	input  logic                    stomp_i,
	input  logic [4:0]              stomp_bno_i,
	input  logic                    nmi_i,
	input  logic                    micro_active_i,
	input  fetch_pc_t               micro_adr_i,
	output fetch_group_t            group_o,
	output logic                    group_valid_o
);

	localparam int LINE_W = NUM_SLOTS * 32;
	localparam logic [LINE_W-1:0] NOP_LINE = {NUM_SLOTS{NOP_INSTR}};

	// The group struct is laid out for a fixed slot count
	if (NUM_SLOTS != GROUP_SLOTS) begin : g_slot_check
		$error("fetch_stage slot count differs from the fetch group layout");
	end

	fetch_pc_t    base;
	fetch_group_t group_next;
	logic         null_line;

	// ===================================================================
	// Slot addresses
	// ===================================================================

	// The micro-machine takes over the fetch address while it runs
	assign base = micro_active_i ? micro_adr_i : pc_i;

	// Normal fetch gives each slot its own word address
	// In micro mode every slot repeats the micro address
	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			group_next.slot_pc[k].bno = base.bno;
			if (micro_active_i)
				group_next.slot_pc[k].pc = base.pc;
			else
				group_next.slot_pc[k].pc = base.pc + 32'(4 * k);
		end
		group_next.line = line_i;
	end

	// ===================================================================
	// Line nulling
	// ===================================================================

	// Any of these turns the whole group into NOPs
	// Stomping only hits paths other than the surviving branch number
	assign null_line = !warm_i
		|| !hit_i
		|| (stomp_i && (base.bno != stomp_bno_i))
		|| nmi_i;

	// ===================================================================
	// Stage register
	// ===================================================================

	// Out of reset the group looks like a NOP fetch from the reset address
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < NUM_SLOTS; k++) begin
				group_o.slot_pc[k].bno <= RESET_BNO;
				group_o.slot_pc[k].pc <= RESET_PC + 32'(4 * k);
			end
			group_o.line <= NOP_LINE;
			group_valid_o <= 1'b0;
		end else if (en_i) begin
			group_o.slot_pc <= group_next.slot_pc;
			if (null_line) begin
				group_o.line <= NOP_LINE;
				group_valid_o <= 1'b0;
			end else begin
				group_o.line <= group_next.line;
				group_valid_o <= 1'b1;
			end
		end
	end

endmodule

// ==== design/icache_lines.sv ====
`timescale 1ns/1ps

module icache_lines import fetch_pkg::*; #(
	parameter int NUM_SLOTS   = 4,
	parameter int CACHE_LINES = 16
) (
	input  logic                    clk,
	input  logic                    rst,
	input  fetch_pc_t               pc_i,
	input  logic                    fill_i,
	input  logic [31:0]             fill_addr_i,
	input  logic [NUM_SLOTS*32-1:0] fill_line_i,
	output logic [NUM_SLOTS*32-1:0] line_o,
	output logic                    hit_o
);

	localparam int LINE_W = NUM_SLOTS * 32;
	localparam int OFF_W = $clog2(NUM_SLOTS * 4);
	localparam int INDEX_W = $clog2(CACHE_LINES);
	localparam int TAG_W = 32 - INDEX_W - OFF_W;

	// Index bits come straight out of the address, so the depth must be 2**n
	if (CACHE_LINES != (1 << INDEX_W)) begin : g_depth_check
		$error("icache_lines needs a power of two line count");
	end

	logic [CACHE_LINES-1:0] valid;
	logic [TAG_W-1:0]       tag_mem [CACHE_LINES];
	logic [LINE_W-1:0]      data_mem [CACHE_LINES];

	logic [INDEX_W-1:0] rd_idx;
	logic [TAG_W-1:0]   rd_tag;
	logic [INDEX_W-1:0] wr_idx;
	logic [TAG_W-1:0]   wr_tag;

	// ===================================================================
	// Lookup
	// ===================================================================

	assign rd_idx = pc_i.pc[OFF_W +: INDEX_W];
	assign rd_tag = pc_i.pc[31 -: TAG_W];

	// Data is read unconditionally, the hit flag says whether to trust it
	assign line_o = data_mem[rd_idx];
	assign hit_o = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);

	// ===================================================================
	// Refill
	// ===================================================================

	assign wr_idx = fill_addr_i[OFF_W +: INDEX_W];
	assign wr_tag = fill_addr_i[31 -: TAG_W];

	// Only the valid bits are cleared, so stale tags are harmless
	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else if (fill_i)
			valid[wr_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (fill_i) begin
			tag_mem[wr_idx] <= wr_tag;
			data_mem[wr_idx] <= fill_line_i;
		end
	end

	// Refills always carry a whole line starting at its first byte
	a_fill_aligned: assert property (
		@(posedge clk) disable iff (rst) fill_i |-> fill_addr_i[OFF_W-1:0] == '0
	);

	// A line just written is found on the next lookup of the same address
	a_fill_then_hit: assert property (
		@(posedge clk) disable iff (rst)
		fill_i |=> (pc_i.pc[31:OFF_W] != $past(fill_addr_i[31:OFF_W])) || hit_o
	);

endmodule

// ==== design/fetch_pc_counter.sv ====
`timescale 1ns/1ps

module fetch_pc_counter import fetch_pkg::*; #(
	parameter int NUM_SLOTS = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      advance_i,
	input  logic      redirect_i,
	input  fetch_pc_t redirect_pc_i,
	input  logic      hold_i,
	output fetch_pc_t pc_o
);

	localparam int LINE_BYTES = NUM_SLOTS * 4;
	localparam int OFF_W = $clog2(LINE_BYTES);

	// Clears the byte offset within a line
	localparam logic [31:0] ALIGN_MASK = ~(32'(LINE_BYTES) - 32'd1);

	// ===================================================================
	// Fetch address register
	// ===================================================================

	// Nothing moves while downstream holds
	// A redirect wins over a normal step and brings its own branch number
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_o.bno <= RESET_BNO;
			pc_o.pc <= RESET_PC;
		end else if (!hold_i) begin
			if (redirect_i) begin
				pc_o.bno <= redirect_pc_i.bno;
				pc_o.pc <= redirect_pc_i.pc & ALIGN_MASK;
			end else if (advance_i) begin
				pc_o.pc <= (pc_o.pc + 32'(LINE_BYTES)) & ALIGN_MASK;
			end
		end
	end

	// Every fetch address points at the start of a line
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (rst) pc_o.pc[OFF_W-1:0] == '0
	);

endmodule

// ==== design/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl #(
	parameter int WARMUP_CYCLES = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic hold_i,
	input  logic redirect_i,
	input  logic cache_hit_i,
	output logic advance_o,
	output logic stage_en_o,
	output logic warm_o,
	output logic fetch_stall_o
);

	// Counter wide enough to reach the last warm-up cycle
	localparam int CNT_W = (WARMUP_CYCLES > 1) ? $clog2(WARMUP_CYCLES) : 1;
	localparam logic [CNT_W-1:0] WARM_LAST = CNT_W'(WARMUP_CYCLES - 1);

	typedef enum logic [1:0] {
		WARMUP,
		RUN,
		MISS
	} state_t;

	state_t state;
	state_t state_next;
	logic [CNT_W-1:0] warm_cnt;

	// ===================================================================
	// State sequencing
	// ===================================================================

	// WARMUP lasts exactly WARMUP_CYCLES clocks after reset
	// RUN drops into MISS on the first lookup that fails
	// MISS waits for the refill or gives up on a redirect
	always_comb begin
		state_next = state;
		case (state)
			WARMUP: begin
				if (warm_cnt == WARM_LAST)
					state_next = RUN;
			end
			RUN: begin
				if (!cache_hit_i && !redirect_i)
					state_next = MISS;
			end
			MISS: begin
				if (cache_hit_i || redirect_i)
					state_next = RUN;
			end
			default: state_next = WARMUP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= WARMUP;
		else
			state <= state_next;
	end

	// The counter only runs while warming up and then parks
	always_ff @(posedge clk) begin
		if (rst)
			warm_cnt <= '0;
		else if (state == WARMUP)
			warm_cnt <= warm_cnt + 1'b1;
	end

	// ===================================================================
	// Outputs
	// ===================================================================

	assign warm_o = (state != WARMUP);

	// Downstream back-pressure freezes the stage register
	assign stage_en_o = !hold_i;

	// The PC only moves past a line that was actually delivered
	assign advance_o = warm_o && cache_hit_i && !hold_i;

	// A failed lookup stalls in the very cycle it is seen
	// and keeps stalling in MISS until the line turns up
	assign fetch_stall_o = warm_o && !cache_hit_i;

	// Back-pressure must never lose a line by stepping the PC
	a_no_advance_on_hold: assert property (
		@(posedge clk) disable iff (rst) hold_i |-> !advance_o
	);

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

	// ===================================================================
	// Fetch group shape
	// ===================================================================

	// Slots per fetch group, which the group struct is built around
	localparam int GROUP_SLOTS = 4;

	// One fetch address tagged with the branch number of its path
	typedef struct packed {
		logic [4:0]  bno;
		logic [31:0] pc;
	} fetch_pc_t;

	// A latched fetch group with one PC per slot
	// Slot 0 sits in the low word of the line
	typedef struct packed {
		fetch_pc_t [GROUP_SLOTS-1:0] slot_pc;
		logic [GROUP_SLOTS*32-1:0]   line;
	} fetch_group_t;

	// ===================================================================
	// Encodings and reset values
	// ===================================================================

	// No-operation instruction word (addi x0, x0, 0)
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

	// First address fetched out of reset, aligned to a line
	localparam logic [31:0] RESET_PC = 32'h0000_1000;

	// Branch number that the reset path carries
	localparam logic [4:0] RESET_BNO = 5'd1;

endpackage
